// ==== Makefile ====
# Verilator build and run of the rv32i core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

SOURCES := $(shell grep -v '^+' $(FILELIST)) rv_mem_functions.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== rv_alu.sv ====
// combinational alu, ten rv32i operations
`timescale 1ns/100ps

module rv_alu (
	input  logic [rv_pkg::xlen-1:0] srca,
	input  logic [rv_pkg::xlen-1:0] srcb,
	input  rv_pkg::alu_op_e alu_op,
	output logic [rv_pkg::xlen-1:0] aluout
);
	import rv_pkg::*;

	logic [4:0] shamt;

	assign shamt = srcb[4:0]; // only low five bits shift

	always_comb begin
		case (alu_op)
			alu_add: aluout = srca + srcb;
			alu_sub: aluout = srca - srcb;
			alu_sll: aluout = srca << shamt;
			alu_slt: aluout = {31'b0, $signed(srca) < $signed(srcb)};
			alu_sltu: aluout = {31'b0, srca < srcb};
			alu_xor: aluout = srca ^ srcb;
			alu_srl: aluout = srca >> shamt;
			alu_sra: aluout = $signed(srca) >>> shamt; // sign fill
			alu_or: aluout = srca | srcb;
			alu_and: aluout = srca & srcb;
			default: aluout = srca + srcb;
		endcase
	end

endmodule

// ==== rv_controller.sv ====
// main decoder for the single-cycle core
// opcode / funct fields to control set and alu operation
`timescale 1ns/100ps

module rv_controller (
	input  logic reset,
	input  logic [rv_pkg::xlen-1:0] instr,
	output logic regwrite,
	output logic memwrite,
	output logic alusrc, // second alu operand is the immediate
	output logic branch,
	output logic jump, // jal
	output logic jalr,
	output rv_pkg::wb_sel_e wb_sel,
	output rv_pkg::alu_op_e alu_op
);
	import rv_pkg::*;

	opcode_e opcode;
	logic [2:0] funct3;
	logic alt; // funct7[5] qualified
	logic reg_we;
	logic mem_we;

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];

	// sub only exists in the reg-reg form; sra / srai share funct3 101
	assign alt = instr[30] & (((opcode == opc_op) && (funct3 == 3'b000)) || (funct3 == 3'b101));

	always_comb begin
		reg_we = 1'b0; // unknown opcodes write nothing
		mem_we = 1'b0;
		alusrc = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		jalr = 1'b0;
		wb_sel = wb_alu;
		alu_op = alu_add; // address adds for ld / st / jalr
		case (opcode)
			opc_op: begin
				reg_we = 1'b1;
				alu_op = alu_op_e'({alt, funct3});
			end
			opc_op_imm: begin
				reg_we = 1'b1;
				alusrc = 1'b1;
				alu_op = alu_op_e'({alt, funct3});
			end
			opc_load: begin
				reg_we = 1'b1;
				alusrc = 1'b1;
				wb_sel = wb_mem;
			end
			opc_store: begin
				mem_we = 1'b1;
				alusrc = 1'b1; // s-type offset picked in datapath
			end
			opc_branch: branch = 1'b1; // compare done outside the alu
			opc_jal: begin
				reg_we = 1'b1;
				jump = 1'b1;
				wb_sel = wb_pc_plus4;
			end
			opc_jalr: begin
				reg_we = 1'b1;
				jalr = 1'b1;
				alusrc = 1'b1;
				wb_sel = wb_pc_plus4;
			end
			opc_lui: begin
				reg_we = 1'b1;
				wb_sel = wb_upper_imm;
			end
			opc_auipc: begin
				reg_we = 1'b1;
				wb_sel = wb_pc_upper;
			end
			default: ;
		endcase
	end

	// no architectural writes while in reset
	assign regwrite = reg_we & ~reset;
	assign memwrite = mem_we & ~reset;

endmodule

// ==== rv_core.sv ====
// single-cycle rv32i core top
// controller, register file and datapath on the memory ports
`timescale 1ns/100ps

module rv_core (
	input  logic clk,
	input  logic reset,
	input  logic [rv_pkg::xlen-1:0] instr, // follows pc in the same cycle
	input  logic [rv_pkg::xlen-1:0] readdata, // follows aluout
	output logic [rv_pkg::xlen-1:0] pc,
	output logic [rv_pkg::xlen-1:0] aluout,
	output logic [rv_pkg::xlen-1:0] writedata,
	output logic memwrite,
	output logic [3:0] byte_en,
	output logic regwrite, // retire trace
	output logic [rv_pkg::reg_aw-1:0] rd,
	output logic [rv_pkg::xlen-1:0] result
);
	import rv_pkg::*;

	logic alusrc, branch, jump, jalr;
	logic [xlen-1:0] rs1_data, rs2_data;
	wb_sel_e wb_sel;
	alu_op_e alu_op;

	assign rd = instr[11:7];

	rv_controller u_ctrl (
		.reset(reset),
		.instr(instr),
		.regwrite(regwrite),
		.memwrite(memwrite),
		.alusrc(alusrc),
		.branch(branch),
		.jump(jump),
		.jalr(jalr),
		.wb_sel(wb_sel),
		.alu_op(alu_op)
	);

	rv_regfile u_rf (
		.clk(clk),
		.regwrite(regwrite),
		.rs1(instr[19:15]),
		.rs2(instr[24:20]),
		.rd(rd),
		.result(result),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	rv_datapath u_dp (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.readdata(readdata),
		.alusrc(alusrc),
		.branch(branch),
		.jump(jump),
		.jalr(jalr),
		.wb_sel(wb_sel),
		.alu_op(alu_op),
		.pc(pc),
		.aluout(aluout),
		.writedata(writedata),
		.result(result),
		.byte_en(byte_en)
	);

endmodule

// ==== rv_core_properties.sv ====
// concurrent checks on the core ports, bound into rv_core
`timescale 1ns/100ps

module rv_core_properties (
	input  logic clk,
	input  logic reset,
	input  logic [rv_pkg::xlen-1:0] pc,
	input  logic memwrite,
	input  logic regwrite
);
	import rv_pkg::*;

	// writes held off during reset
	a_quiet_in_reset: assert property (@(posedge clk) reset |-> !memwrite && !regwrite)
		else $error("write enable active while reset is high");

	a_first_fetch: assert property (@(posedge clk) $fell(reset) |-> pc == reset_pc)
		else $error("first fetch after reset not at the reset address");

	a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc lost word alignment");

	// one destination per instruction
	a_one_write: assert property (@(posedge clk) !(memwrite && regwrite))
		else $error("memory and register write in the same cycle");

endmodule

bind rv_core rv_core_properties u_props (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.memwrite(memwrite),
	.regwrite(regwrite)
);

// ==== rv_datapath.sv ====
// pc register and next-pc select, immediates, operand muxes
// write-back select, load extension, store lanes and byte enables
`timescale 1ns/100ps

module rv_datapath (
	input  logic clk,
	input  logic reset,
	input  logic [rv_pkg::xlen-1:0] instr,
	input  logic [rv_pkg::xlen-1:0] rs1_data,
	input  logic [rv_pkg::xlen-1:0] rs2_data,
	input  logic [rv_pkg::xlen-1:0] readdata,
	input  logic alusrc,
	input  logic branch,
	input  logic jump,
	input  logic jalr,
	input  rv_pkg::wb_sel_e wb_sel,
	input  rv_pkg::alu_op_e alu_op,
	output logic [rv_pkg::xlen-1:0] pc,
	output logic [rv_pkg::xlen-1:0] aluout, // also the data address
	output logic [rv_pkg::xlen-1:0] writedata,
	output logic [rv_pkg::xlen-1:0] result,
	output logic [3:0] byte_en
);
	import rv_pkg::*;

	`include "rv_mem_functions.svh"

	logic [2:0] funct3;
	logic [xlen-1:0] iimm, simm, bimm, uimm, jimm;
	logic [xlen-1:0] signimm;
	logic [xlen-1:0] srcb;
	logic [xlen-1:0] pc_plus4;
	logic [3:0] store_be;
	logic is_store;
	logic br_taken;

	assign funct3 = instr[14:12];
	assign is_store = (instr[6:0] == opc_store);

	// immediate extraction, all sign extended from instr[31]
	assign iimm = {{20{instr[31]}}, instr[31:20]}; // op-imm, load, jalr
	assign simm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign bimm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign uimm = {instr[31:12], 12'b0};
	assign jimm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign signimm = is_store ? simm : iimm;
	assign srcb = alusrc ? signimm : rs2_data; // operand b mux
	assign pc_plus4 = pc + 32'd4;

	rv_alu u_alu (
		.srca(rs1_data),
		.srcb(srcb),
		.alu_op(alu_op),
		.aluout(aluout)
	);

	assign br_taken = br_compute(branch, funct3, rs1_data, rs2_data);

	// next pc; jalr wins, then jal, then a taken branch
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= reset_pc;
		else if (jalr)
			pc <= {aluout[xlen-1:1], 1'b0}; // target bit 0 cleared
		else if (jump)
			pc <= pc + jimm;
		else if (br_taken)
			pc <= pc + bimm;
		else
			pc <= pc_plus4;
	end

	// write-back value, also the retire trace
	always_comb begin
		case (wb_sel)
			wb_mem: result = load_compute(funct3, aluout[1:0], readdata);
			wb_pc_plus4: result = pc_plus4;
			wb_upper_imm: result = uimm;
			wb_pc_upper: result = pc + uimm;
			default: result = aluout;
		endcase
	end

	// store lanes from the low address bits
	always_comb begin
		writedata = store_compute(funct3, aluout[1:0], rs2_data, store_be);
		byte_en = is_store ? store_be : 4'b0000; // quiet unless storing
	end

endmodule

// ==== rv_mem_functions.svh ====
// load extension, store lane placement with byte enables
// and the six branch compares
`ifndef RV_MEM_FUNCTIONS_SVH
`define RV_MEM_FUNCTIONS_SVH

// pick byte / half out of the read word, sign or zero extend
function automatic logic [xlen-1:0] load_compute(
	input logic [2:0] funct3,
	input logic [1:0] lane,
	input logic [xlen-1:0] rdata
);
	logic [7:0] b;
	logic [15:0] h;
	b = rdata[{lane, 3'b000} +: 8];
	h = rdata[{lane[1], 4'b0000} +: 16]; // half is naturally aligned
	case (funct3)
		3'b000: load_compute = {{24{b[7]}}, b}; // lb
		3'b001: load_compute = {{16{h[15]}}, h}; // lh
		3'b100: load_compute = {24'b0, b}; // lbu
		3'b101: load_compute = {16'b0, h}; // lhu
		default: load_compute = rdata; // lw
	endcase
endfunction

// shift store data into its lane, byte enables follow the lane
function automatic logic [xlen-1:0] store_compute(
	input logic [2:0] funct3,
	input logic [1:0] lane,
	input logic [xlen-1:0] data,
	output logic [3:0] be
);
	case (funct3[1:0])
		2'b00: begin // sb
			store_compute = {24'b0, data[7:0]} << {lane, 3'b000};
			be = 4'b0001 << lane;
		end
		2'b01: begin // sh
			store_compute = {16'b0, data[15:0]} << {lane[1], 4'b0000};
			be = lane[1] ? 4'b1100 : 4'b0011;
		end
		default: begin // sw
			store_compute = data;
			be = 4'b1111;
		end
	endcase
endfunction

// taken only when the instruction is a branch and its compare holds
function automatic logic br_compute(
	input logic branch,
	input logic [2:0] funct3,
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] b
);
	logic cond;
	case (funct3)
		3'b000: cond = (a == b); // beq
		3'b001: cond = (a != b); // bne
		3'b100: cond = ($signed(a) < $signed(b)); // blt
		3'b101: cond = ($signed(a) >= $signed(b)); // bge
		3'b110: cond = (a < b); // bltu
		3'b111: cond = (a >= b); // bgeu
		default: cond = 1'b0; // reserved encodings never branch
	endcase
	return branch & cond;
endfunction

`endif

// ==== rv_pkg.sv ====
// core-wide widths and the reset fetch address
// enums for major opcodes, alu operations and write-back source
package rv_pkg;

	localparam int xlen = 32; // data and address width
	localparam int nregs = 32; // architectural registers
	localparam int reg_aw = 5; // register index width
	localparam logic [xlen-1:0] reset_pc = '0; // first fetch after reset

	// rv32i major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011, // reg-reg alu
		opc_op_imm = 7'b0010011, // reg-imm alu
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111
	} opcode_e;

	// encoded as {funct7[5], funct3}, so the decoder can build it straight from the fields
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000, // add with funct7[5]
		alu_sra  = 4'b1101  // srl with funct7[5]
	} alu_op_e;

	// register write-back source
	typedef enum logic [2:0] {
		wb_alu,
		wb_mem,       // extended load data
		wb_pc_plus4,  // link value for jal / jalr
		wb_upper_imm, // lui
		wb_pc_upper   // auipc
	} wb_sel_e;

endpackage

// ==== rv_regfile.sv ====
// 32 x 32 integer register file
// two async reads, one clocked write, x0 reads as zero
`timescale 1ns/100ps

module rv_regfile (
	input  logic clk,
	input  logic regwrite,
	input  logic [rv_pkg::reg_aw-1:0] rs1,
	input  logic [rv_pkg::reg_aw-1:0] rs2,
	input  logic [rv_pkg::reg_aw-1:0] rd,
	input  logic [rv_pkg::xlen-1:0] result,
	output logic [rv_pkg::xlen-1:0] rs1_data,
	output logic [rv_pkg::xlen-1:0] rs2_data
);
	import rv_pkg::*;

	logic [xlen-1:0] regs [nregs];

	// write port, x0 writes dropped
	always_ff @(posedge clk) begin
		if (regwrite && (rd != '0))
			regs[rd] <= result;
	end

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== tb_rv_core.sv ====
// testbench for the single-cycle rv32i core
// memory models, program builder, reference model and the comparing process
`timescale 1ns/100ps

module tb_rv_core;
	import rv_pkg::*;

	localparam int half_period = 20; // 40 ns clock
	localparam int reset_cycles = 10;
	localparam int drive_dly = 2; // after the rising edge
	localparam int imem_words = 512;
	localparam int dmem_words = 256;
	localparam int n_random = 200; // random alu instructions

	logic clk;
	logic reset;
	logic [xlen-1:0] instr, readdata;
	logic [xlen-1:0] pc, aluout, writedata, result;
	logic memwrite, regwrite;
	logic [3:0] byte_en;
	logic [4:0] rd;

	logic [xlen-1:0] imem [imem_words];
	logic [xlen-1:0] dmem [dmem_words];

	// reference machine state
	logic [xlen-1:0] sh_reg [32];
	logic [xlen-1:0] sh_mem [dmem_words];
	logic [xlen-1:0] sh_pc;

	int n_instr; // words in the program
	logic [xlen-1:0] end_pc; // final self-jump
	int errors;
	int cycles;
	int cycle_limit;
	bit done;

	rv_core u_dut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.readdata(readdata),
		.pc(pc),
		.aluout(aluout),
		.writedata(writedata),
		.memwrite(memwrite),
		.byte_en(byte_en),
		.regwrite(regwrite),
		.rd(rd),
		.result(result)
	);

	initial clk = 1'b0;
	always #half_period clk = ~clk;

	// both memories answer in the same cycle
	assign instr = imem[pc[10:2]];
	assign readdata = dmem[aluout[9:2]];

	// data memory write under byte enables
	always @(posedge clk) begin
		if (memwrite) begin
			for (int i = 0; i < 4; i++)
				if (byte_en[i])
					dmem[aluout[9:2]][i*8 +: 8] <= writedata[i*8 +: 8];
		end
	end

	function automatic logic [31:0] dmem_fill(input int i);
		return (32'(i) * 32'h0101_0101) ^ 32'hc3a5_5a3c; // index in every lane
	endfunction

	// instruction encoders
	function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
		input int f3, input int rdx, input logic [6:0] opc);
		return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rdx), opc};
	endfunction

	function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
		input int rdx, input logic [6:0] opc);
		return {12'(imm), 5'(rs1), 3'(f3), 5'(rdx), opc};
	endfunction

	function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
		input int f3);
		logic [11:0] m;
		m = 12'(imm);
		return {m[11:5], 5'(rs2), 5'(rs1), 3'(f3), m[4:0], opc_store};
	endfunction

	function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
		input int f3);
		logic [12:0] m;
		m = 13'(imm);
		return {m[12], m[10:5], 5'(rs2), 5'(rs1), 3'(f3), m[4:1], m[11], opc_branch};
	endfunction

	function automatic logic [31:0] u_type(input int imm20, input int rdx,
		input logic [6:0] opc);
		return {20'(imm20), 5'(rdx), opc};
	endfunction

	function automatic logic [31:0] j_type(input int imm, input int rdx);
		logic [20:0] m;
		m = 21'(imm);
		return {m[20], m[10:1], m[11], m[19:12], 5'(rdx), opc_jal};
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[n_instr] = w;
		n_instr++;
	endtask

	// lui + addi, upper part rounded for the sign of the low twelve bits
	task automatic load_const(input int r, input logic [31:0] v);
		emit(u_type(int'((v + 32'h800) >> 12), r, opc_lui));
		emit(i_type(int'(v[11:0]), r, 0, r, opc_op_imm));
	endtask

	task automatic build_program();
		int f3, alt, imm;
		int imm_f3 [6] = '{0, 2, 3, 4, 6, 7};
		int br_f3 [6] = '{0, 1, 4, 5, 6, 7};
		int tk_rs1 [6] = '{2, 1, 1, 2, 2, 1}; // x1 = -5, x2 = 3
		int tk_rs2 [6] = '{2, 2, 2, 1, 1, 2};
		int nt_rs1 [6] = '{1, 2, 2, 1, 1, 2};
		int nt_rs2 [6] = '{2, 2, 1, 2, 2, 1};
		for (int r = 1; r < 32; r++)
			load_const(r, $urandom()); // no register left unknown
		emit(i_type(-5, 0, 0, 1, opc_op_imm));
		emit(i_type(3, 0, 0, 2, opc_op_imm));
		for (int k = 0; k < 8; k++)
			emit(r_type(0, 2, 1, k, 3 + k, opc_op)); // add .. and into x3..x10
		emit(r_type(32, 2, 1, 0, 11, opc_op)); // sub
		emit(r_type(32, 2, 1, 5, 12, opc_op)); // sra
		for (int k = 0; k < 6; k++)
			emit(i_type(-3, 1, imm_f3[k], 13 + k, opc_op_imm));
		emit(i_type(4, 1, 1, 19, opc_op_imm)); // slli
		emit(i_type(4, 1, 5, 20, opc_op_imm)); // srli
		emit(i_type(1024 + 4, 1, 5, 21, opc_op_imm)); // srai
		emit(u_type('hdead0, 22, opc_lui));
		emit(u_type('h12345, 23, opc_auipc));
		// stores then loads around 0x100
		emit(i_type(256, 0, 0, 24, opc_op_imm));
		load_const(25, 32'h89ab_c5ef);
		emit(s_type(0, 25, 24, 2)); // sw
		emit(s_type(5, 1, 24, 0)); // sb lane 1
		emit(s_type(7, 25, 24, 0)); // sb lane 3
		emit(s_type(10, 25, 24, 1)); // sh upper half
		emit(s_type(12, 1, 24, 1)); // sh lower half
		emit(i_type(0, 24, 2, 26, opc_load)); // lw
		emit(i_type(3, 24, 0, 27, opc_load)); // lb, negative byte
		emit(i_type(3, 24, 4, 28, opc_load)); // lbu
		emit(i_type(2, 24, 1, 29, opc_load)); // lh, negative half
		emit(i_type(2, 24, 5, 30, opc_load)); // lhu
		emit(i_type(5, 24, 0, 31, opc_load));
		emit(i_type(4, 24, 2, 26, opc_load)); // stored bytes over fill
		emit(i_type(10, 24, 1, 27, opc_load));
		emit(i_type(12, 24, 5, 28, opc_load));
		emit(i_type(64, 24, 2, 29, opc_load)); // untouched word
		emit(i_type(-3, 24, 0, 30, opc_load)); // negative offset
		// each branch taken over a marker, then not taken
		for (int k = 0; k < 6; k++) begin
			emit(b_type(8, tk_rs2[k], tk_rs1[k], br_f3[k]));
			emit(i_type(1, 3, 0, 3, opc_op_imm)); // skipped
			emit(b_type(8, nt_rs2[k], nt_rs1[k], br_f3[k]));
			emit(i_type(1, 3, 0, 3, opc_op_imm));
		end
		emit(i_type(3, 0, 0, 4, opc_op_imm)); // short backward loop
		emit(i_type(-1, 4, 0, 4, opc_op_imm));
		emit(b_type(-4, 0, 4, 1)); // bne x4, x0
		emit(j_type(8, 5)); // jal over a marker
		emit(i_type(1, 3, 0, 3, opc_op_imm));
		emit(u_type(0, 6, opc_auipc));
		emit(i_type(13, 6, 0, 7, opc_jalr)); // odd target, lands 3 words on
		emit(i_type(1, 3, 0, 3, opc_op_imm));
		emit(i_type(55, 0, 0, 0, opc_op_imm)); // x0 writes dropped
		emit(u_type('h12345, 0, opc_lui));
		emit(r_type(0, 0, 0, 0, 8, opc_op));
		for (int n = 0; n < n_random; n++) begin
			f3 = $urandom_range(7, 0);
			alt = $urandom_range(1, 0);
			if ($urandom_range(1, 0) == 1) begin
				if (f3 == 1)
					imm = $urandom_range(31, 0);
				else if (f3 == 5)
					imm = alt * 1024 + $urandom_range(31, 0); // srli or srai
				else
					imm = $urandom_range(4095, 0);
				emit(i_type(imm, $urandom_range(31, 0), f3, $urandom_range(31, 0),
					opc_op_imm));
			end else begin
				emit(r_type((f3 == 0 || f3 == 5) ? alt * 32 : 0, $urandom_range(31, 0),
					$urandom_range(31, 0), f3, $urandom_range(31, 0), opc_op));
			end
		end
		end_pc = 32'(n_instr * 4);
		emit(j_type(0, 0)); // self-jump
	endtask

	// rv32i alu semantics, alt is funct7 bit 5 where it matters
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// executes one instruction on the shadow state
	function automatic void ref_step(input logic [31:0] ins, output logic [31:0] npc,
		output logic rw, output logic [4:0] rdx, output logic [31:0] res,
		output logic mw, output logic [31:0] addr, output logic [31:0] wdata,
		output logic [3:0] be);
		logic [31:0] a, b, ii, si, bi, ji, word;
		logic [2:0] f3;
		logic [7:0] byt;
		logic [15:0] half;
		logic take;
		f3 = ins[14:12];
		a = sh_reg[ins[19:15]];
		b = sh_reg[ins[24:20]];
		ii = {{20{ins[31]}}, ins[31:20]};
		si = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		bi = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		ji = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		npc = sh_pc + 32'd4;
		rw = 1'b0;
		rdx = ins[11:7];
		res = '0;
		mw = 1'b0;
		addr = '0;
		wdata = '0;
		be = '0;
		case (ins[6:0])
			opc_op: begin
				rw = 1'b1;
				res = alu_ref(f3, ins[30], a, b);
			end
			opc_op_imm: begin
				rw = 1'b1;
				res = alu_ref(f3, (f3 == 3'd5) && ins[30], a, ii); // no subi
			end
			opc_lui: begin
				rw = 1'b1;
				res = {ins[31:12], 12'b0};
			end
			opc_auipc: begin
				rw = 1'b1;
				res = sh_pc + {ins[31:12], 12'b0};
			end
			opc_jal: begin
				rw = 1'b1;
				res = sh_pc + 32'd4;
				npc = sh_pc + ji;
			end
			opc_jalr: begin
				rw = 1'b1;
				res = sh_pc + 32'd4;
				npc = (a + ii) & ~32'd1;
			end
			opc_branch: begin
				case (f3)
					3'd0: take = (a == b);
					3'd1: take = (a != b);
					3'd4: take = ($signed(a) < $signed(b));
					3'd5: take = ($signed(a) >= $signed(b));
					3'd6: take = (a < b);
					default: take = (a >= b);
				endcase
				if (take)
					npc = sh_pc + bi;
			end
			opc_load: begin
				rw = 1'b1;
				addr = a + ii;
				word = sh_mem[addr[9:2]];
				byt = 8'(word >> {addr[1:0], 3'b000});
				half = 16'(word >> {addr[1], 4'b0000});
				case (f3)
					3'd0: res = {{24{byt[7]}}, byt};
					3'd1: res = {{16{half[15]}}, half};
					3'd4: res = {24'b0, byt};
					3'd5: res = {16'b0, half};
					default: res = word;
				endcase
			end
			opc_store: begin
				mw = 1'b1;
				addr = a + si;
				wdata = b << {addr[1:0], 3'b000}; // lanes outside be are masked off
				case (f3)
					3'd0: be = 4'b0001 << addr[1:0];
					3'd1: be = 4'b0011 << {addr[1], 1'b0};
					default: be = 4'b1111;
				endcase
				for (int i = 0; i < 4; i++)
					if (be[i])
						sh_mem[addr[9:2]][i*8 +: 8] = wdata[i*8 +: 8];
			end
			default: ; // unknown, no effect
		endcase
		if (rw && rdx != 5'd0)
			sh_reg[rdx] = res;
		sh_pc = npc;
	endfunction

	function automatic logic [31:0] lane_mask(input logic [3:0] be);
		return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
	endfunction

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// compare at the falling edge, where every output is settled
	always @(negedge clk) begin
		logic [xlen-1:0] e_npc, e_res, e_addr, e_wdata, mask, cur;
		logic e_rw, e_mw;
		logic [4:0] e_rd;
		logic [3:0] e_be;
		if (!reset && !done) begin
			check_equal("pc", pc, sh_pc);
			cur = sh_pc;
			ref_step(imem[sh_pc[10:2]], e_npc, e_rw, e_rd, e_res, e_mw, e_addr, e_wdata, e_be);
			check_equal("regwrite", 32'(regwrite), 32'(e_rw));
			if (e_rw) begin
				check_equal("rd", 32'(rd), 32'(e_rd));
				check_equal("result", result, e_res);
			end
			check_equal("memwrite", 32'(memwrite), 32'(e_mw));
			check_equal("byte_en", 32'(byte_en), 32'(e_be));
			if (e_mw) begin
				mask = lane_mask(e_be);
				check_equal("store address", aluout, e_addr);
				check_equal("writedata", writedata & mask, e_wdata & mask);
			end
			if (cur == end_pc)
				done = 1'b1; // self-jump reached
		end
	end

	// run limit from the program length
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit && !done) begin
			$display("timeout: final self-jump not reached within %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		errors = 0;
		cycles = 0;
		n_instr = 0;
		done = 1'b0;
		cycle_limit = 1 << 30; // replaced once the program is built
		void'($urandom(32'h30fa));
		sh_pc = reset_pc;
		for (int i = 0; i < 32; i++)
			sh_reg[i] = '0;
		for (int i = 0; i < imem_words; i++)
			imem[i] = '0;
		for (int i = 0; i < dmem_words; i++) begin
			dmem[i] = dmem_fill(i);
			sh_mem[i] = dmem_fill(i);
		end
		build_program();
		cycle_limit = 2 * n_instr + reset_cycles;
		repeat (reset_cycles) @(posedge clk);
		#drive_dly reset = 1'b0;
		wait (done);
		$display("errors: %0d over %0d program words", errors, n_instr);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+.
rv_pkg.sv
rv_alu.sv
rv_controller.sv
rv_regfile.sv
rv_datapath.sv
rv_core.sv
rv_core_properties.sv
tb_rv_core.sv
